// ==== verilog/refill_pkg.sv ====
package refill_pkg;

    // Bus and line geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * DATA_W;
    localparam int OFFS_W     = $clog2(LINE_W / 8);

    // Cache ports seen by the refill unit
    localparam int NUM_PORTS = 2;
    localparam int PORT_DC   = 0;
    localparam int PORT_IC   = 1;

    // Set associativity and tree PLRU width
    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int PLRU_W   = NUM_WAYS - 1;

    // Store width as sent by the data cache
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    // Bus master state
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_REFILL
    } arb_state_e;

endpackage : refill_pkg

// ==== verilog/refill_port.sv ====
`timescale 1ns/10ps

module refill_port (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Cache side
    input  logic                          miss_i,
    input  logic [refill_pkg::ADDR_W-1:0] miss_addr_i,
    input  logic                          hit_i,
    input  logic [refill_pkg::WAY_W-1:0]  hit_way_i,
    output logic                          refill_valid_o,
    output logic [refill_pkg::WAY_W-1:0]  refill_way_o,
    // Arbiter side
    input  logic                          done_i,
    output logic                          pend_o,
    output logic [refill_pkg::ADDR_W-1:0] line_addr_o
);

    import refill_pkg::*;

    logic [PLRU_W-1:0] plru;
    logic [WAY_W-1:0]  victim;
    logic [WAY_W-1:0]  fill_way;
    logic [ADDR_W-1:0] line_addr;

    // Mark the accessed way as most recently used
    function automatic logic [PLRU_W-1:0] plru_touch(
        input logic [PLRU_W-1:0] tree,
        input logic [WAY_W-1:0]  way
    );
        logic [PLRU_W-1:0] next;
        next    = tree;
        next[0] = ~way[1];
        if (way[1]) begin
            next[2] = ~way[0];
        end else begin
            next[1] = ~way[0];
        end
        return next;
    endfunction

    // Follow the tree pointers down to the LRU way
    always_comb begin
        if (plru[0]) begin
            victim = {1'b1, plru[2]};
        end else begin
            victim = {1'b0, plru[1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_o         <= 1'b0;
            refill_valid_o <= 1'b0;
            plru           <= '0;
        end else begin
            refill_valid_o <= done_i;
            if (miss_i) begin
                pend_o <= 1'b1;
            end else if (done_i) begin
                pend_o <= 1'b0;
            end
            // Refilled way becomes MRU, same as a hit
            if (done_i) begin
                plru <= plru_touch(plru, fill_way);
            end else if (hit_i) begin
                plru <= plru_touch(plru, hit_way_i);
            end
        end
    end

    // Miss address and chosen way, held until the refill returns
    always_ff @(posedge clk_i) begin
        if (miss_i) begin
            line_addr <= {miss_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            fill_way  <= victim;
        end
    end

    assign line_addr_o  = line_addr;
    assign refill_way_o = fill_way;

    a_no_miss_while_pend: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) miss_i |-> !pend_o
    );

    a_no_hit_with_done: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(hit_i && done_i)
    );

endmodule : refill_port

// ==== verilog/refill_arbiter.sv ====
`timescale 1ns/10ps

module refill_arbiter (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    // Refill requests from the ports
    input  logic [refill_pkg::NUM_PORTS-1:0] pend_i,
    input  logic [refill_pkg::ADDR_W-1:0]    line_addr_dc_i,
    input  logic [refill_pkg::ADDR_W-1:0]    line_addr_ic_i,
    output logic [refill_pkg::NUM_PORTS-1:0] done_o,
    output logic [refill_pkg::LINE_W-1:0]    refill_line_o,
    // Data cache stores
    input  logic                             st_req_i,
    input  logic [refill_pkg::ADDR_W-1:0]    st_addr_i,
    input  logic [refill_pkg::DATA_W-1:0]    st_data_i,
    input  refill_pkg::mem_size_e            st_size_i,
    output logic                             st_ack_o,
    // Wishbone classic master
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [refill_pkg::ADDR_W-1:0]    wb_adr_o,
    output logic [refill_pkg::DATA_W-1:0]    wb_dat_o,
    output logic [3:0]                       wb_sel_o,
    input  logic [refill_pkg::DATA_W-1:0]    wb_dat_i,
    input  logic                             wb_ack_i
);

    import refill_pkg::*;

    arb_state_e                      state;
    logic                            last_port;
    logic                            grant_port;
    logic [$clog2(LINE_WORDS)-1:0]   beat;
    logic                            last_ack;
    logic                            store_go;
    logic [ADDR_W-1:0]               grant_addr;
    logic [DATA_W-1:0]               st_wdata;
    logic [3:0]                      st_sel;
    logic [LINE_W-1:0]               line;

    // Held request is already served while its ack is out
    assign store_go = st_req_i && !st_ack_o;

    // Round robin, the port not served last wins a tie
    assign grant_port = pend_i[~last_port] ? ~last_port : last_port;
    assign grant_addr = (grant_port == 1'(PORT_IC)) ? line_addr_ic_i : line_addr_dc_i;

    // Byte lanes and selects for the store
    always_comb begin
        case (st_size_i)
            MEM_BYTE: begin
                st_wdata = st_data_i << {st_addr_i[1:0], 3'b000};
                st_sel   = 4'b0001 << st_addr_i[1:0];
            end
            MEM_HALF: begin
                st_wdata = st_data_i << {st_addr_i[1], 4'b0000};
                st_sel   = 4'b0011 << {st_addr_i[1], 1'b0};
            end
            default: begin
                st_wdata = st_data_i;
                st_sel   = 4'b1111;
            end
        endcase
    end

    assign last_ack = (state == ST_REFILL) && wb_ack_i && (&beat);

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            done_o[p] = last_ack && (last_port == 1'(p));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            st_ack_o  <= 1'b0;
            beat      <= '0;
            last_port <= 1'b0;
        end else begin
            st_ack_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Stores go ahead of refills
                    if (store_go) begin
                        state    <= ST_STORE;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                    end else if (|pend_i) begin
                        state     <= ST_REFILL;
                        wb_cyc_o  <= 1'b1;
                        wb_stb_o  <= 1'b1;
                        beat      <= '0;
                        last_port <= grant_port;
                    end
                end
                ST_STORE: begin
                    if (wb_ack_i) begin
                        state    <= ST_IDLE;
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        st_ack_o <= 1'b1;
                    end
                end
                ST_REFILL: begin
                    if (wb_ack_i) begin
                        beat <= beat + 1'b1;
                        if (&beat) begin
                            state    <= ST_IDLE;
                            wb_cyc_o <= 1'b0;
                            wb_stb_o <= 1'b0;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields and line assembly
    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE) begin
            if (store_go) begin
                wb_adr_o <= {st_addr_i[ADDR_W-1:2], 2'b00};
                wb_we_o  <= 1'b1;
                wb_dat_o <= st_wdata;
                wb_sel_o <= st_sel;
            end else begin
                wb_adr_o <= grant_addr;
                wb_we_o  <= 1'b0;
                wb_sel_o <= 4'b1111;
            end
        end else if (state == ST_REFILL && wb_ack_i) begin
            wb_adr_o <= wb_adr_o + ADDR_W'(DATA_W / 8);
            // Word i ends up at bits 32i after the last beat
            line     <= {wb_dat_i, line[LINE_W-1:DATA_W]};
        end
    end

    assign refill_line_o = line;

    a_stall_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)
            && $stable(wb_dat_o) && $stable(wb_sel_o)
    );

endmodule : refill_arbiter

// ==== verilog/refill_top.sv ====
`timescale 1ns/10ps

module refill_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Data cache
    input  logic                          dc_miss_i,
    input  logic [refill_pkg::ADDR_W-1:0] dc_miss_addr_i,
    input  logic                          dc_hit_i,
    input  logic [refill_pkg::WAY_W-1:0]  dc_hit_way_i,
    output logic                          dc_refill_valid_o,
    output logic [refill_pkg::WAY_W-1:0]  dc_refill_way_o,
    // Instruction cache
    input  logic                          ic_miss_i,
    input  logic [refill_pkg::ADDR_W-1:0] ic_miss_addr_i,
    input  logic                          ic_hit_i,
    input  logic [refill_pkg::WAY_W-1:0]  ic_hit_way_i,
    output logic                          ic_refill_valid_o,
    output logic [refill_pkg::WAY_W-1:0]  ic_refill_way_o,
    output logic [refill_pkg::LINE_W-1:0] refill_line_o,
    // Stores
    input  logic                          st_req_i,
    input  logic [refill_pkg::ADDR_W-1:0] st_addr_i,
    input  logic [refill_pkg::DATA_W-1:0] st_data_i,
    input  refill_pkg::mem_size_e         st_size_i,
    output logic                          st_ack_o,
    // Wishbone
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic                          wb_we_o,
    output logic [refill_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [refill_pkg::DATA_W-1:0] wb_dat_o,
    output logic [3:0]                    wb_sel_o,
    input  logic [refill_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                          wb_ack_i
);

    import refill_pkg::*;

    logic [NUM_PORTS-1:0] pend;
    logic [NUM_PORTS-1:0] done;
    logic [NUM_PORTS-1:0] refill_valid;
    logic [ADDR_W-1:0]    line_addr  [NUM_PORTS];
    logic [WAY_W-1:0]     refill_way [NUM_PORTS];

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        refill_port u_port (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .miss_i         ((p == PORT_DC) ? dc_miss_i      : ic_miss_i),
            .miss_addr_i    ((p == PORT_DC) ? dc_miss_addr_i : ic_miss_addr_i),
            .hit_i          ((p == PORT_DC) ? dc_hit_i       : ic_hit_i),
            .hit_way_i      ((p == PORT_DC) ? dc_hit_way_i   : ic_hit_way_i),
            .refill_valid_o (refill_valid[p]),
            .refill_way_o   (refill_way[p]),
            .done_i         (done[p]),
            .pend_o         (pend[p]),
            .line_addr_o    (line_addr[p])
        );
    end

    assign dc_refill_valid_o = refill_valid[PORT_DC];
    assign dc_refill_way_o   = refill_way[PORT_DC];
    assign ic_refill_valid_o = refill_valid[PORT_IC];
    assign ic_refill_way_o   = refill_way[PORT_IC];

    refill_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pend_i         (pend),
        .line_addr_dc_i (line_addr[PORT_DC]),
        .line_addr_ic_i (line_addr[PORT_IC]),
        .done_o         (done),
        .refill_line_o  (refill_line_o),
        .st_req_i       (st_req_i),
        .st_addr_i      (st_addr_i),
        .st_data_i      (st_data_i),
        .st_size_i      (st_size_i),
        .st_ack_o       (st_ack_o),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_sel_o       (wb_sel_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

endmodule : refill_top

// ==== bench/tb_refill.sv ====
`timescale 1ns/10ps

module tb_refill;

    import refill_pkg::*;

    localparam int          N_OPS      = 300;
    localparam int          MAX_CYCLES = N_OPS * 40;
    localparam logic [31:0] FILL_KEY   = 32'h3c5a_96e1;
    // Word index limited to 0..31 so stores and refills share lines
    localparam logic [31:0] ADDR_MASK  = 32'hffff_f07f;

    logic                 clk_i;
    logic                 rst_n_i;
    logic [NUM_PORTS-1:0] miss;
    logic [NUM_PORTS-1:0] hit;
    logic [NUM_PORTS-1:0] refill_valid;
    logic [ADDR_W-1:0]    miss_addr  [NUM_PORTS];
    logic [WAY_W-1:0]     hit_way    [NUM_PORTS];
    logic [WAY_W-1:0]     refill_way [NUM_PORTS];
    logic [LINE_W-1:0]    refill_line;
    logic                 st_req;
    logic [ADDR_W-1:0]    st_addr;
    logic [DATA_W-1:0]    st_data;
    mem_size_e            st_size;
    logic                 st_ack;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic                 wb_ack;
    logic [ADDR_W-1:0]    wb_adr;
    logic [DATA_W-1:0]    wb_wdat;
    logic [DATA_W-1:0]    wb_rdat;
    logic [3:0]           wb_sel;

    // Bus memory and the model's view of it
    logic [DATA_W-1:0] mem     [1024];
    logic [DATA_W-1:0] exp_mem [1024];
    logic [PLRU_W-1:0] plru_m  [NUM_PORTS];
    logic [WAY_W-1:0]  way_m   [NUM_PORTS];
    logic [ADDR_W-1:0] line_m  [NUM_PORTS];
    logic [NUM_PORTS-1:0] busy;
    logic [NUM_PORTS-1:0] exp_rv;
    logic              st_busy;
    logic              exp_ack;
    logic [3:0]        sel_m;
    logic [DATA_W-1:0] dat_m;
    arb_state_e        cur_op;
    int                cur_port;
    int                last_port;
    int                beat;
    int                wait_left;
    int                cycles;
    int                issued;
    int                n_miss;
    int                n_refill;
    int                n_store;
    int                n_ack;
    logic              stalled;
    logic [ADDR_W-1:0] hold_adr;
    logic [DATA_W-1:0] hold_dat;
    logic [3:0]        hold_sel;
    logic              finished;
    logic [31:0]       seed;

    refill_top dut0 (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .dc_miss_i         (miss[PORT_DC]),
        .dc_miss_addr_i    (miss_addr[PORT_DC]),
        .dc_hit_i          (hit[PORT_DC]),
        .dc_hit_way_i      (hit_way[PORT_DC]),
        .dc_refill_valid_o (refill_valid[PORT_DC]),
        .dc_refill_way_o   (refill_way[PORT_DC]),
        .ic_miss_i         (miss[PORT_IC]),
        .ic_miss_addr_i    (miss_addr[PORT_IC]),
        .ic_hit_i          (hit[PORT_IC]),
        .ic_hit_way_i      (hit_way[PORT_IC]),
        .ic_refill_valid_o (refill_valid[PORT_IC]),
        .ic_refill_way_o   (refill_way[PORT_IC]),
        .refill_line_o     (refill_line),
        .st_req_i          (st_req),
        .st_addr_i         (st_addr),
        .st_data_i         (st_data),
        .st_size_i         (st_size),
        .st_ack_o          (st_ack),
        .wb_cyc_o          (wb_cyc),
        .wb_stb_o          (wb_stb),
        .wb_we_o           (wb_we),
        .wb_adr_o          (wb_adr),
        .wb_dat_o          (wb_wdat),
        .wb_sel_o          (wb_sel),
        .wb_dat_i          (wb_rdat),
        .wb_ack_i          (wb_ack)
    );

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "refill testbench stopped at the first error");
    endtask

    task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_way(input string name, input logic [WAY_W-1:0] exp,
                             input logic [WAY_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_op(input string name, input arb_state_e exp, input arb_state_e act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] val);
        seed = xorshift32(seed);
        val  = seed;
    endtask

    // Tree walk: bit 0 picks the LRU half, bit 1 or 2 the LRU way in it
    function automatic logic [WAY_W-1:0] plru_victim(input logic [PLRU_W-1:0] t);
        return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
    endfunction

    function automatic logic [PLRU_W-1:0] plru_access(input logic [PLRU_W-1:0] t,
                                                      input logic [WAY_W-1:0] w);
        logic [PLRU_W-1:0] n;
        n = t;
        n[0] = (w < 2) ? 1'b1 : 1'b0;
        case (w)
            2'd0: n[1] = 1'b1;
            2'd1: n[1] = 1'b0;
            2'd2: n[2] = 1'b1;
            default: n[2] = 1'b0;
        endcase
        return n;
    endfunction

    function automatic logic [DATA_W-1:0] lane_mask(input logic [3:0] sel);
        logic [DATA_W-1:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{sel[b]}};
        end
        return m;
    endfunction

    task automatic store_lanes();
        case (st_size)
            MEM_BYTE: begin
                sel_m = 4'b0001 << st_addr[1:0];
                dat_m = st_data << (8 * st_addr[1:0]);
            end
            MEM_HALF: begin
                sel_m = 4'b0011 << (2 * st_addr[1]);
                dat_m = st_data << (16 * st_addr[1]);
            end
            default: begin
                sel_m = 4'b1111;
                dat_m = st_data;
            end
        endcase
    endtask

    task automatic run_cycle();
        logic [31:0]          r;
        logic [9:0]           a;
        logic [NUM_PORTS-1:0] pend_now;
        logic                 op_done;
        arb_state_e           actual_op;
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: operations still outstanding after %0d cycles", MAX_CYCLES);
            abort_run();
        end
        // Responses from the last rising edge
        expect_bit("st_ack_o", exp_ack, st_ack);
        if (st_ack) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_m[b]) begin
                    exp_mem[st_addr[11:2]][8*b +: 8] = dat_m[8*b +: 8];
                end
            end
            st_busy = 1'b0;
            n_ack++;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            expect_bit(p == PORT_DC ? "dc_refill_valid_o" : "ic_refill_valid_o",
                       exp_rv[p], refill_valid[p]);
            if (refill_valid[p]) begin
                a = line_m[p][11:2];
                check_way(p == PORT_DC ? "dc_refill_way_o" : "ic_refill_way_o",
                          way_m[p], refill_way[p]);
                check_line("refill_line_o", {exp_mem[a + 10'd3], exp_mem[a + 10'd2],
                           exp_mem[a + 10'd1], exp_mem[a]}, refill_line);
                plru_m[p] = plru_access(plru_m[p], way_m[p]);
                busy[p]   = 1'b0;
                n_refill++;
            end
        end
        exp_ack = 1'b0;
        exp_rv  = '0;

        // Memory side
        if (wb_cyc !== wb_stb) begin
            $display("wb_stb_o and wb_cyc_o disagree");
            abort_run();
        end
        actual_op = !wb_cyc ? ST_IDLE : (wb_we ? ST_STORE : ST_REFILL);
        expect_op("bus operation", cur_op, actual_op);
        if (stalled) begin
            check_word("wb_adr_o", hold_adr, wb_adr);
            check_word("wb_dat_o", hold_dat, wb_wdat);
            check_sel("wb_sel_o", hold_sel, wb_sel);
        end
        stalled = 1'b0;
        op_done = 1'b0;
        wb_ack  = 1'b0;
        wb_rdat = '0;
        if (cur_op != ST_IDLE) begin
            if (wait_left < 0) begin
                draw(r);
                wait_left = int'(r[1:0]);
            end
            if (wait_left > 0) begin
                wait_left--;
                stalled  = 1'b1;
                hold_adr = wb_adr;
                hold_dat = wb_wdat;
                hold_sel = wb_sel;
            end else begin
                wait_left = -1;
                wb_ack    = 1'b1;
                if (cur_op == ST_STORE) begin
                    check_word("wb_adr_o", st_addr & ~ADDR_W'(3), wb_adr);
                    check_sel("wb_sel_o", sel_m, wb_sel);
                    check_word("wb_dat_o", dat_m & lane_mask(sel_m), wb_wdat & lane_mask(sel_m));
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            mem[wb_adr[11:2]][8*b +: 8] = wb_wdat[8*b +: 8];
                        end
                    end
                    exp_ack = 1'b1;
                    op_done = 1'b1;
                end else begin
                    check_word("wb_adr_o", line_m[cur_port] + ADDR_W'(4 * beat), wb_adr);
                    wb_rdat = mem[wb_adr[11:2]];
                    beat++;
                    if (beat == LINE_WORDS) begin
                        exp_rv[cur_port] = 1'b1;
                        op_done          = 1'b1;
                    end
                end
            end
        end

        // New cache requests
        pend_now = busy;
        miss     = '0;
        hit      = '0;
        if (!st_busy) begin
            st_req = 1'b0;
        end
        if (issued < N_OPS) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                draw(r);
                if (!busy[p] && r[31:29] == 3'd0) begin
                    draw(r);
                    miss[p]      = 1'b1;
                    miss_addr[p] = r & ADDR_MASK;
                    way_m[p]     = plru_victim(plru_m[p]);
                    line_m[p]    = miss_addr[p] & ~ADDR_W'(LINE_W / 8 - 1);
                    busy[p]      = 1'b1;
                    issued++;
                    n_miss++;
                end else if (!busy[p] && r[31:29] < 3'd3) begin
                    hit[p]     = 1'b1;
                    hit_way[p] = r[1:0];
                    plru_m[p]  = plru_access(plru_m[p], r[1:0]);
                end
            end
            draw(r);
            if (!st_busy && r[31:30] == 2'd0) begin
                draw(r);
                st_addr = r & ADDR_MASK;
                st_size = (r[8:7] == 2'd0) ? MEM_BYTE : (r[8:7] == 2'd1) ? MEM_HALF : MEM_WORD;
                draw(r);
                st_data = r;
                st_req  = 1'b1;
                store_lanes();
                st_busy = 1'b1;
                issued++;
                n_store++;
            end
        end

        // Next bus operation: waiting store first, then round robin
        if (cur_op == ST_IDLE) begin
            if (st_busy && !st_ack) begin
                cur_op = ST_STORE;
            end else if (pend_now != '0) begin
                cur_port  = pend_now[1 - last_port] ? 1 - last_port : last_port;
                last_port = cur_port;
                cur_op    = ST_REFILL;
                beat      = 0;
            end
        end else if (op_done) begin
            cur_op = ST_IDLE;
        end
        // Every miss answered by a refill and every store by an ack
        finished = issued >= N_OPS && n_refill == n_miss && n_ack == n_store
                   && cur_op == ST_IDLE;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        seed    = 32'hf68d_c543;
        rst_n_i = 1'b0;
        miss    = '0;
        hit     = '0;
        st_req  = 1'b0;
        st_addr = '0;
        st_data = '0;
        st_size = MEM_WORD;
        wb_ack  = 1'b0;
        wb_rdat = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            miss_addr[p] = '0;
            hit_way[p]   = '0;
            plru_m[p]    = '0;
            way_m[p]     = '0;
            line_m[p]    = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            mem[i]     = (32'(i) << 2) ^ FILL_KEY;
            exp_mem[i] = mem[i];
        end
        busy      = '0;
        exp_rv    = '0;
        st_busy   = 1'b0;
        exp_ack   = 1'b0;
        cur_op    = ST_IDLE;
        cur_port  = PORT_DC;
        last_port = PORT_DC;
        beat      = 0;
        wait_left = -1;
        cycles    = 0;
        issued    = 0;
        n_miss    = 0;
        n_refill  = 0;
        n_store   = 0;
        n_ack     = 0;
        stalled   = 1'b0;
        finished  = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        do begin
            @(negedge clk_i);
            run_cycle();
        end while (!finished);
        $display("** PASS **");
        $finish;
    end

endmodule : tb_refill

// ==== src.f ====
verilog/refill_pkg.sv
verilog/refill_port.sv
verilog/refill_arbiter.sv
verilog/refill_top.sv
bench/tb_refill.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_refill -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_refill" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
